// File: ecc_85.f
+incdir+hw
hw/ecc_pkg.sv
hw/ecc_parity_gen.sv
hw/ecc_check_correct.sv
hw/ecc_85_top.sv
verification/tb_clock_gen.sv
verification/tb_ecc_85.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the ecc_85 testbench with verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing -Wno-fatal --top-module tb_ecc_85 -f ecc_85.f \
    -o sim_ecc_85 > build.log 2>&1 \
    && ./obj_dir/sim_ecc_85 | tee sim.log \
    || echo "build or run error, see build.log and sim.log"

grep -qx "Simulation completed successfully" sim.log \
    && echo "RESULT: PASS" \
    || { echo "RESULT: FAIL"; exit 1; }

// File: verification/tb_ecc_85.sv
`timescale 1ns/1ps

`include "ecc_settings.svh"

module tb_ecc_85;

    localparam int DW       = `ECC_DATA_WIDTH;
    localparam int PW       = `ECC_PARITY_WIDTH;
    localparam int HW       = `ECC_HAMMING_WIDTH;
    localparam int NUM_BITS = DW + PW;

    // about 480 test cycles and 16 of reset, four times over.
    localparam int CYCLE_LIMIT = 2000;

    logic          clk;
    logic          rst;
    logic [DW-1:0] data_in;
    logic [DW-1:0] data_out;
    logic [PW-1:0] parity_in;
    logic [PW-1:0] parity_out;
    logic          bypass;
    logic          sbit_err;
    logic          dbit_err;

    integer seed;
    int     error_count;
    int     check_count;
    int     test_count;
    int     cycle_count = 0;

    tb_clock_gen clock_gen (
        .clk (clk),
        .rst (rst)
    );

    ecc_85_top uut (
        .data_in    (data_in),
        .data_out   (data_out),
        .parity_in  (parity_in),
        .parity_out (parity_out),
        .bypass     (bypass),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: tests did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    // codeword position of data bit index, counting from 3 and skipping powers of two.
    function automatic int ref_position(input int index);
        int pos;
        int count;
        pos = 2;
        count = -1;
        while (count < index) begin
            pos++;
            if ((pos & (pos - 1)) != 0) begin
                count++;
            end
        end
        return pos;
    endfunction

    function automatic logic [PW-1:0] ref_parity(input logic [DW-1:0] data);
        logic [PW-1:0] p;
        logic [HW-1:0] pos;
        p = '0;
        for (int i = 0; i < DW; i++) begin
            pos = HW'(ref_position(i));
            for (int k = 0; k < HW; k++) begin
                if (pos[k]) begin
                    p[k] = p[k] ^ data[i];
                end
            end
            if ($countones(pos) % 2 == 0) begin
                p[HW] = p[HW] ^ data[i];
            end
        end
        return p;
    endfunction

    function automatic logic [DW-1:0] random_word();
        logic [95:0] raw;
        raw = {$random(seed), $random(seed), $random(seed)};
        return raw[DW-1:0];
    endfunction

    // index into the data bits followed by the check bits.
    function automatic int random_bit();
        return int'($unsigned($random(seed)) % NUM_BITS);
    endfunction

    task automatic flip_bit(input int idx, inout logic [DW-1:0] d, inout logic [PW-1:0] p);
        if (idx < DW) begin
            d[idx] = ~d[idx];
        end else begin
            p[idx - DW] = ~p[idx - DW];
        end
    endtask

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("mismatch %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic drive_and_sample(input logic [DW-1:0] d, input logic [PW-1:0] p,
                                    input logic b);
        @(negedge clk);
        data_in   = d;
        parity_in = p;
        bypass    = b;
        @(posedge clk);
    endtask

    task automatic check_response(input string name, input logic [DW-1:0] exp_data,
                                  input logic exp_sbit, input logic exp_dbit);
        check_value({name, " parity_out"}, 128'(ref_parity(data_in)), 128'(parity_out));
        check_value({name, " data_out"}, 128'(exp_data), 128'(data_out));
        check_value({name, " sbit_err"}, 128'(exp_sbit), 128'(sbit_err));
        check_value({name, " dbit_err"}, 128'(exp_dbit), 128'(dbit_err));
    endtask

    task automatic report_test(input string name, input int vectors, input int errors_before);
        test_count++;
        $display("test %s: %0d vectors, %0d errors", name, vectors, error_count - errors_before);
    endtask

    task automatic test_clean_words();
        logic [DW-1:0] d;
        int errs;
        errs = error_count;
        for (int n = 0; n < 200; n++) begin
            d = random_word();
            drive_and_sample(d, ref_parity(d), 1'b0);
            check_response("clean_words", d, 1'b0, 1'b0);
        end
        report_test("clean_words", 200, errs);
    endtask

    task automatic test_single_data();
        logic [DW-1:0] d;
        logic [DW-1:0] rx;
        int errs;
        errs = error_count;
        for (int i = 0; i < DW; i++) begin
            d = random_word();
            rx = d;
            rx[i] = ~rx[i];
            drive_and_sample(rx, ref_parity(d), 1'b0);
            check_response("single_data", d, 1'b1, 1'b0);
        end
        report_test("single_data", DW, errs);
    endtask

    task automatic test_single_check();
        logic [DW-1:0] d;
        logic [PW-1:0] p;
        int errs;
        errs = error_count;
        for (int k = 0; k < PW; k++) begin
            d = random_word();
            p = ref_parity(d);
            p[k] = ~p[k];
            drive_and_sample(d, p, 1'b0);
            check_response("single_check", d, 1'b1, 1'b0);
        end
        report_test("single_check", PW, errs);
    endtask

    task automatic test_double();
        logic [DW-1:0] d;
        logic [PW-1:0] p;
        int b1;
        int b2;
        int errs;
        errs = error_count;
        for (int n = 0; n < 100; n++) begin
            d = random_word();
            p = ref_parity(d);
            b1 = random_bit();
            b2 = random_bit();
            while (b2 == b1) begin
                b2 = random_bit();
            end
            flip_bit(b1, d, p);
            flip_bit(b2, d, p);
            drive_and_sample(d, p, 1'b0);
            check_response("double", d, 1'b0, 1'b1);
        end
        report_test("double", 100, errs);
    endtask

    // odd weight syndromes above the highest data position, 93 up to 127.
    task automatic test_unused_syndrome();
        logic [DW-1:0] d;
        logic [HW-1:0] pos;
        logic [PW-1:0] syn;
        int errs;
        errs = error_count;
        for (int n = 93; n < 128; n++) begin
            d = random_word();
            pos = HW'(n);
            syn = {($countones(pos) % 2 == 0), pos};
            drive_and_sample(d, ref_parity(d) ^ syn, 1'b0);
            check_response("unused_syndrome", d, 1'b0, 1'b1);
        end
        report_test("unused_syndrome", 35, errs);
    endtask

    task automatic test_bypass();
        logic [DW-1:0] d;
        logic [PW-1:0] p;
        int b1;
        int b2;
        int errs;
        errs = error_count;
        for (int n = 0; n < 50; n++) begin
            d = random_word();
            p = ref_parity(d);
            b1 = random_bit();
            flip_bit(b1, d, p);
            // every other vector carries a second flip.
            if (n % 2 == 1) begin
                b2 = random_bit();
                while (b2 == b1) begin
                    b2 = random_bit();
                end
                flip_bit(b2, d, p);
            end
            drive_and_sample(d, p, 1'b1);
            check_response("bypass", d, 1'b0, 1'b0);
        end
        report_test("bypass", 50, errs);
    endtask

    initial begin
        data_in     = '0;
        parity_in   = '0;
        bypass      = 1'b0;
        seed        = 30;
        error_count = 0;
        check_count = 0;
        test_count  = 0;
        do begin
            @(posedge clk);
        end while (rst !== 1'b0);
        test_clean_words();
        test_single_data();
        test_single_check();
        test_double();
        test_unused_syndrome();
        test_bypass();
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset is released on a falling edge, away from the sampling edge.
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: hw/ecc_85_top.sv
`timescale 1ns/1ps

`include "ecc_settings.svh"

module ecc_85_top (
    input  logic [`ECC_DATA_WIDTH-1:0]   data_in,
    output logic [`ECC_DATA_WIDTH-1:0]   data_out,
    input  logic [`ECC_PARITY_WIDTH-1:0] parity_in,
    output logic [`ECC_PARITY_WIDTH-1:0] parity_out,
    input  logic                         bypass,
    output logic                         sbit_err,
    output logic                         dbit_err
);

    // check bits of the word on data_in.
    logic [`ECC_PARITY_WIDTH-1:0] parity_calc;

    ecc_parity_gen u_parity_gen (
        .data   (data_in),
        .parity (parity_calc)
    );

    // the same check bits both leave the block and feed the decoder.
    assign parity_out = parity_calc;

    ecc_check_correct u_check_correct (
        .data_in     (data_in),
        .parity_in   (parity_in),
        .parity_calc (parity_calc),
        .bypass      (bypass),
        .data_out    (data_out),
        .sbit_err    (sbit_err),
        .dbit_err    (dbit_err)
    );

endmodule

// File: hw/ecc_check_correct.sv
`timescale 1ns/1ps

`include "ecc_settings.svh"

module ecc_check_correct (
    input  logic [`ECC_DATA_WIDTH-1:0]   data_in,
    input  logic [`ECC_PARITY_WIDTH-1:0] parity_in,
    input  logic [`ECC_PARITY_WIDTH-1:0] parity_calc,
    input  logic                         bypass,
    output logic [`ECC_DATA_WIDTH-1:0]   data_out,
    output logic                         sbit_err,
    output logic                         dbit_err
);

    import ecc_pkg::*;

    logic [`ECC_PARITY_WIDTH-1:0]  syndrome;
    logic [`ECC_HAMMING_WIDTH-1:0] syn_pos;
    logic                          syn_zero;
    logic                          syn_odd;
    logic                          syn_check_bit;
    logic [`ECC_DATA_WIDTH-1:0]    mask;
    logic                          data_hit;
    logic [`ECC_DATA_WIDTH-1:0]    data_fixed;
    ecc_status_t                   status;

    // syndrome is received check bits against freshly generated ones.
    assign syndrome = parity_in ^ parity_calc;
    assign syn_pos  = syndrome[`ECC_HAMMING_WIDTH-1:0];
    assign syn_zero = (syndrome == '0);
    assign syn_odd  = ^syndrome;

    // a single failed check bit leaves exactly one syndrome bit set.
    assign syn_check_bit = $onehot(syndrome);

    // one-hot correction mask.
    // an odd weight syndrome whose low bits name a data position points at
    // the flipped data bit. even weight means two flips, so no correction.
    always_comb begin
        for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
            mask[i] = syn_odd && (syn_pos == data_position(i));
        end
    end

    assign data_hit = |mask;

    // classify the syndrome.
    always_comb begin
        if (syn_zero) begin
            status = ECC_OK;
        end else if (syn_check_bit || data_hit) begin
            status = ECC_SINGLE;
        end else begin
            // even weight, or odd weight naming no data position.
            status = ECC_DOUBLE;
        end
    end

    assign data_fixed = data_in ^ mask;

    // bypass passes the word through untouched and hides both flags.
    always_comb begin
        if (bypass) begin
            data_out = data_in;
            sbit_err = 1'b0;
            dbit_err = 1'b0;
        end else begin
            data_out = data_fixed;
            sbit_err = (status == ECC_SINGLE);
            dbit_err = (status == ECC_DOUBLE);
        end
    end

endmodule

// File: hw/ecc_parity_gen.sv
`timescale 1ns/1ps

`include "ecc_settings.svh"

module ecc_parity_gen (
    input  logic [`ECC_DATA_WIDTH-1:0]   data,
    output logic [`ECC_PARITY_WIDTH-1:0] parity
);

    import ecc_pkg::*;

    // codeword position of every data bit, constant after elaboration.
    ecc_pos_t pos_map [`ECC_DATA_WIDTH];

    for (genvar i = 0; i < `ECC_DATA_WIDTH; i++) begin : g_pos
        assign pos_map[i] = data_position(i);
    end

    for (genvar k = 0; k < `ECC_PARITY_WIDTH; k++) begin : g_check
        // data bits covered by this check bit.
        logic [`ECC_DATA_WIDTH-1:0] member;

        if (k < `ECC_HAMMING_WIDTH) begin : g_addr
            // bit k of the position selects the data bit.
            always_comb begin
                for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
                    member[i] = pos_map[i][k];
                end
            end
        end else begin : g_overall
            // overall parity over the even weight positions.
            always_comb begin
                for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
                    member[i] = position_is_even_weight(pos_map[i]);
                end
            end
        end

        assign parity[k] = ^(data & member);
    end

endmodule

// File: hw/ecc_pkg.sv
`include "ecc_settings.svh"

package ecc_pkg;

    // a codeword position, wide enough for the highest data position.
    typedef logic [`ECC_HAMMING_WIDTH-1:0] ecc_pos_t;

    // decoder verdict, before bypass is applied.
    typedef enum logic [1:0] {
        ECC_OK     = 2'd0,
        ECC_SINGLE = 2'd1,
        ECC_DOUBLE = 2'd2
    } ecc_status_t;

    // data bits fill the codeword positions from 3 upward and skip every
    // power of two, since those positions carry the hamming check bits.
    // data bit 0 lands at 3, data bit 84 at 92.
    function automatic ecc_pos_t data_position(input int unsigned index);
        int unsigned pos;
        pos = index + 3;
        // positions 1 and 2 are already covered by the offset above.
        for (int k = 2; k < `ECC_HAMMING_WIDTH; k++) begin
            if (pos >= (32'd1 << k)) begin
                pos = pos + 1;
            end
        end
        return ecc_pos_t'(pos);
    endfunction

    // high when the position has an even number of ones.
    // such data bits feed the overall check bit, which keeps the syndrome
    // of every single data error at odd weight.
    function automatic logic position_is_even_weight(input ecc_pos_t pos);
        logic odd;
        odd = 1'b0;
        for (int k = 0; k < `ECC_HAMMING_WIDTH; k++) begin
            odd = odd ^ pos[k];
        end
        return ~odd;
    endfunction

endpackage

// File: hw/ecc_settings.svh
`ifndef ECC_SETTINGS_SVH
`define ECC_SETTINGS_SVH

// width of the protected data word.
`define ECC_DATA_WIDTH 85

// check bits that address a codeword position.
// positions up to 127 fit, the highest data bit sits at 92.
`define ECC_HAMMING_WIDTH 7

// all check bits, the top one is the overall parity.
`define ECC_PARITY_WIDTH 8

`endif
